// File: common/divSqrtCfgPkg.sv
`default_nettype none

package divSqrtCfgPkg;

  //////////////////////////////////////////////////////////////////////
  // Operand formats
  //////////////////////////////////////////////////////////////////////

  // Integer operand, quotient and remainder width
  localparam int XLEN = 32;
  // Fraction bits of half and single precision
  localparam int NF_H = 10;
  localparam int NF_S = 23;

  //////////////////////////////////////////////////////////////////////
  // Recurrence and step counter
  //////////////////////////////////////////////////////////////////////

  // Radix 2, one quotient bit per step
  localparam int LOGR = 1;
  localparam int RK = 1;
  // Index of the highest dividend bit, 0 to 31
  localparam int DIVBLEN = 5;
  // Step count, up to 32
  localparam int DURLEN = 6;
  // Residual and radicand, holds the 52 bit single-precision radicand
  localparam int RESW = 56;

endpackage

`default_nettype wire

// File: common/divSqrtOpPkg.sv
`default_nettype none

package divSqrtOpPkg;

  //////////////////////////////////////////////////////////////////////
  // Operation encodings
  //////////////////////////////////////////////////////////////////////

  // Significand format
  typedef enum logic {
    FMT_H = 1'b0,
    FMT_S = 1'b1
  } fmtT;

  // Operation, integer division is unsigned only
  typedef enum logic [1:0] {
    OP_FDIV  = 2'd0,
    OP_FSQRT = 2'd1,
    OP_IDIV  = 2'd2
  } opT;

endpackage

`default_nettype wire

// File: common/divSqrtIterIf.sv
`default_nettype none

// Prepared operands from the preprocessor into the recurrence
interface divSqrtIterIf;

  // Division: upper part is the starting residual, low XLEN bits the
  // left-aligned dividend bits. Square root: left-aligned radicand
  logic [divSqrtCfgPkg::RESW-1:0] x;
  // Divisor, zero extended
  logic [divSqrtCfgPkg::RESW-1:0] d;
  logic                           isSqrt;
  logic                           isInt;
  // One cycle strobe, fields above are valid with it and held after
  logic                           load;

  // Preprocessor side
  modport pre (output x, d, isSqrt, isInt, load);

  // Recurrence side
  modport iter (input x, d, isSqrt, isInt, load);

endinterface

`default_nettype wire

// File: divsqrt/divSqrtCycles.sv
`default_nettype none

module divSqrtCycles (
  input  divSqrtOpPkg::fmtT                  fmt,
  input  divSqrtOpPkg::opT                   op,
  input  logic [divSqrtCfgPkg::DIVBLEN-1:0]  nE,
  output logic [divSqrtCfgPkg::DURLEN-1:0]   steps
);

  // Fraction width and fractional bit count
  logic [divSqrtCfgPkg::DURLEN+1:0] nf;
  logic [divSqrtCfgPkg::DURLEN+1:0] fbits;
  // Steps for a floating-point operation
  logic [divSqrtCfgPkg::DURLEN-1:0] fpSteps;

  always_comb begin
    // Fraction width for the format
    if (fmt == divSqrtOpPkg::FMT_S)
      nf = (divSqrtCfgPkg::DURLEN + 2)'(divSqrtCfgPkg::NF_S);
    else
      nf = (divSqrtCfgPkg::DURLEN + 2)'(divSqrtCfgPkg::NF_H);

    // Nf plus round and guard bits plus one
    // The extra bit is the integer bit in division and shift room in sqrt
    fbits = nf + (divSqrtCfgPkg::DURLEN + 2)'(2 + divSqrtCfgPkg::LOGR);

    // Bits retired per step sets the step count
    fpSteps = (divSqrtCfgPkg::DURLEN)'((fbits - 1) / divSqrtCfgPkg::RK + 1);

    // Short dividends finish early
    if (op == divSqrtOpPkg::OP_IDIV)
      steps = (divSqrtCfgPkg::DURLEN)'(nE) + (divSqrtCfgPkg::DURLEN)'(1);
    else
      steps = fpSteps;
  end

endmodule

`default_nettype wire

// File: divsqrt/divSqrtPreproc.sv
`default_nettype none

module divSqrtPreproc (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              start,
  input  divSqrtOpPkg::opT                  op,
  input  divSqrtOpPkg::fmtT                 fmt,
  input  logic [divSqrtCfgPkg::XLEN-1:0]    opA,
  input  logic [divSqrtCfgPkg::XLEN-1:0]    opB,
  output divSqrtOpPkg::opT                  opLatched,
  output divSqrtOpPkg::fmtT                 fmtLatched,
  output logic [divSqrtCfgPkg::DIVBLEN-1:0] nE,
  output logic                              divByZero,
  output logic [divSqrtCfgPkg::XLEN-1:0]    dividend,
  divSqrtIterIf.pre                         iterBus
);

  // Significands with the hidden one
  logic [divSqrtCfgPkg::NF_S:0]         mA;
  logic [divSqrtCfgPkg::NF_S:0]         mB;
  logic [divSqrtCfgPkg::DURLEN-1:0]     nf;
  // Highest set dividend bit
  logic [divSqrtCfgPkg::DIVBLEN-1:0]    hiBit;
  logic [divSqrtCfgPkg::XLEN-1:0]       aligned;
  logic [divSqrtCfgPkg::RESW-1:0]       radicand;
  logic [divSqrtCfgPkg::RESW-1:0]       xNext;
  logic [divSqrtCfgPkg::RESW-1:0]       dNext;

  //////////////////////////////////////////////////////////////////////
  // Operand preparation
  //////////////////////////////////////////////////////////////////////

  // Index of the top one, 0 for a zero dividend
  always_comb begin
    hiBit = '0;
    for (int i = 0; i < divSqrtCfgPkg::XLEN; i++)
      if (opA[i])
        hiBit = (divSqrtCfgPkg::DIVBLEN)'(i);
  end

  always_comb begin
    if (fmt == divSqrtOpPkg::FMT_S) begin
      nf = (divSqrtCfgPkg::DURLEN)'(divSqrtCfgPkg::NF_S);
      mA = {1'b1, opA[divSqrtCfgPkg::NF_S-1:0]};
      mB = {1'b1, opB[divSqrtCfgPkg::NF_S-1:0]};
    end else begin
      nf = (divSqrtCfgPkg::DURLEN)'(divSqrtCfgPkg::NF_H);
      mA = {{(divSqrtCfgPkg::NF_S - divSqrtCfgPkg::NF_H){1'b0}}, 1'b1,
            opA[divSqrtCfgPkg::NF_H-1:0]};
      mB = {{(divSqrtCfgPkg::NF_S - divSqrtCfgPkg::NF_H){1'b0}}, 1'b1,
            opB[divSqrtCfgPkg::NF_H-1:0]};
    end

    // Top dividend bit moves to the MSB, nE+1 steps consume it all
    aligned = opA << (divSqrtCfgPkg::XLEN - 1 - hiBit);
    // Radicand mA*2^(Nf+4), an even 2*(Nf+3) bit field left-aligned
    radicand = (divSqrtCfgPkg::RESW)'(mA) << (nf + 4);

    case (op)
      divSqrtOpPkg::OP_FSQRT: begin
        xNext = radicand << (divSqrtCfgPkg::RESW - 2 * (nf + 3));
        dNext = '0;
      end
      divSqrtOpPkg::OP_IDIV: begin
        xNext = (divSqrtCfgPkg::RESW)'(aligned);
        dNext = (divSqrtCfgPkg::RESW)'(opB);
      end
      default: begin
        // mA/2 is below mB, so the first quotient bit is the integer bit
        xNext = {(divSqrtCfgPkg::RESW - divSqrtCfgPkg::XLEN)'(mA >> 1), mA[0],
                 {(divSqrtCfgPkg::XLEN - 1){1'b0}}};
        dNext = (divSqrtCfgPkg::RESW)'(mB);
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Operand registers
  //////////////////////////////////////////////////////////////////////

  // Load pulses the cycle after an accepted start
  always_ff @(posedge clk) begin
    if (!rstN) begin
      iterBus.load <= 1'b0;
      opLatched    <= divSqrtOpPkg::OP_FDIV;
      fmtLatched   <= divSqrtOpPkg::FMT_H;
    end else begin
      iterBus.load <= start;
      if (start) begin
        opLatched  <= op;
        fmtLatched <= fmt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      iterBus.x      <= xNext;
      iterBus.d      <= dNext;
      iterBus.isSqrt <= (op == divSqrtOpPkg::OP_FSQRT);
      iterBus.isInt  <= (op == divSqrtOpPkg::OP_IDIV);
      nE             <= (op == divSqrtOpPkg::OP_IDIV) ? hiBit : '0;
      divByZero      <= (op == divSqrtOpPkg::OP_IDIV) && (opB == '0);
      dividend       <= opA;
    end
  end

endmodule

`default_nettype wire

// File: divsqrt/divSqrtIter.sv
`default_nettype none

module divSqrtIter (
  input  logic                           clk,
  input  logic                           rstN,
  divSqrtIterIf.iter                     iterBus,
  input  logic                           stepEn,
  output logic [divSqrtCfgPkg::XLEN-1:0] q,
  output logic [divSqrtCfgPkg::XLEN-1:0] rem,
  output logic                           remNonZero
);

  // Partial remainder
  logic [divSqrtCfgPkg::RESW-1:0] resQ;
  // Dividend or radicand bits still to bring down, MSB first
  logic [divSqrtCfgPkg::RESW-1:0] shQ;
  // Quotient or root
  logic [divSqrtCfgPkg::XLEN-1:0] qQ;
  logic [divSqrtCfgPkg::RESW-1:0] shifted;
  logic [divSqrtCfgPkg::RESW-1:0] trial;
  logic [divSqrtCfgPkg::RESW-1:0] diff;
  logic                           fits;

  //////////////////////////////////////////////////////////////////////
  // One restoring step
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (iterBus.isSqrt) begin
      // Bring down two radicand bits, try 4*root + 1
      shifted = {resQ[divSqrtCfgPkg::RESW-3:0], shQ[divSqrtCfgPkg::RESW-1 -: 2]};
      trial   = (divSqrtCfgPkg::RESW)'({qQ, 2'b01});
    end else begin
      // Bring down one dividend bit, try the divisor
      shifted = {resQ[divSqrtCfgPkg::RESW-2:0], shQ[divSqrtCfgPkg::RESW-1]};
      trial   = iterBus.d;
    end
    fits = (shifted >= trial);
    diff = shifted - trial;
  end

  //////////////////////////////////////////////////////////////////////
  // Recurrence registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      resQ <= '0;
      qQ   <= '0;
    end else if (iterBus.load) begin
      // Only FP division starts with a nonzero residual
      if (iterBus.isSqrt || iterBus.isInt)
        resQ <= '0;
      else
        resQ <= (divSqrtCfgPkg::RESW)'(iterBus.x[divSqrtCfgPkg::RESW-1:divSqrtCfgPkg::XLEN]);
      qQ <= '0;
    end else if (stepEn) begin
      resQ <= fits ? diff : shifted;
      qQ   <= {qQ[divSqrtCfgPkg::XLEN-2:0], fits};
    end
  end

  always_ff @(posedge clk) begin
    if (iterBus.load) begin
      if (iterBus.isSqrt)
        shQ <= iterBus.x;
      else
        shQ <= {iterBus.x[divSqrtCfgPkg::XLEN-1:0],
                {(divSqrtCfgPkg::RESW - divSqrtCfgPkg::XLEN){1'b0}}};
    end else if (stepEn) begin
      // Sqrt consumes two bits per step
      shQ <= iterBus.isSqrt ? (shQ << 2) : (shQ << 1);
    end
  end

  assign q          = qQ;
  assign rem        = resQ[divSqrtCfgPkg::XLEN-1:0];
  assign remNonZero = |resQ;

endmodule

`default_nettype wire

// File: divsqrt/divSqrtCtrl.sv
`default_nettype none

module divSqrtCtrl (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             start,
  input  logic                             load,
  input  logic [divSqrtCfgPkg::DURLEN-1:0] steps,
  output logic                             stepEn,
  output logic                             finish,
  output logic                             busy
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } stateT;

  stateT                            stateQ;
  stateT                            stateD;
  // Steps still to go
  logic [divSqrtCfgPkg::DURLEN-1:0] cntQ;
  // RUN, past the load cycle
  logic                             running;

  // Counter is stale during load, so that cycle does not step
  assign running = (stateQ == RUN) && !load;
  assign stepEn  = running && (cntQ != '0);
  assign finish  = running && (cntQ == '0);
  // DONE covers the cycle with the done pulse
  assign busy    = (stateQ != IDLE);

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      // Starts only count here, so busy masks them
      IDLE:    if (start) stateD = RUN;
      RUN:     if (finish) stateD = DONE;
      DONE:    stateD = IDLE;
      default: stateD = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      stateQ <= IDLE;
      cntQ   <= '0;
    end else begin
      stateQ <= stateD;
      if (load)
        cntQ <= steps;
      else if (stepEn)
        cntQ <= cntQ - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: divsqrt/divSqrtPostproc.sv
`default_nettype none

module divSqrtPostproc (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           finish,
  input  divSqrtOpPkg::opT               op,
  input  logic                           divByZero,
  input  logic [divSqrtCfgPkg::XLEN-1:0] dividend,
  input  logic [divSqrtCfgPkg::XLEN-1:0] q,
  input  logic [divSqrtCfgPkg::XLEN-1:0] rem,
  input  logic                           remNonZero,
  output logic                           done,
  output logic [divSqrtCfgPkg::XLEN-1:0] result,
  output logic                           sticky,
  output logic [divSqrtCfgPkg::XLEN-1:0] remainder
);

  // Done trails finish by one cycle
  always_ff @(posedge clk) begin
    if (!rstN)
      done <= 1'b0;
    else
      done <= finish;
  end

  // Result held until the next finish
  always_ff @(posedge clk) begin
    if (finish) begin
      if (op == divSqrtOpPkg::OP_IDIV) begin
        sticky <= 1'b0;
        // x/0 gives all ones, remainder x
        if (divByZero) begin
          result    <= '1;
          remainder <= dividend;
        end else begin
          result    <= q;
          remainder <= rem;
        end
      end else begin
        // Any residual left means inexact
        result    <= q;
        sticky    <= remNonZero;
        remainder <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/divSqrtTop.sv
`default_nettype none

module divSqrtTop (
  input  logic              clk,
  input  logic              rstN,
  input  logic              start,
  input  divSqrtOpPkg::opT  op,
  input  divSqrtOpPkg::fmtT fmt,
  input  logic [31:0]       opA,
  input  logic [31:0]       opB,
  output logic              busy,
  output logic              done,
  output logic [31:0]       result,
  output logic              sticky,
  output logic [31:0]       remainder
);

  divSqrtIterIf iterBus ();

  divSqrtOpPkg::opT  opLatched;
  divSqrtOpPkg::fmtT fmtLatched;
  logic [4:0]        nE;
  logic [5:0]        steps;
  logic              startOk;
  logic              divByZero;
  logic [31:0]       dividend;
  logic              stepEn;
  logic              finish;
  logic [31:0]       q;
  logic [31:0]       rem;
  logic              remNonZero;

  // Operands are only taken when idle
  assign startOk = start & ~busy;

  //////////////////////////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////////////////////////

  divSqrtPreproc u_divSqrtPreproc (
    .clk, .rstN, .start(startOk), .op, .fmt, .opA, .opB,
    .opLatched, .fmtLatched, .nE, .divByZero, .dividend,
    .iterBus(iterBus)
  );

  divSqrtCycles u_divSqrtCycles (
    .fmt(fmtLatched), .op(opLatched), .nE, .steps
  );

  divSqrtCtrl u_divSqrtCtrl (
    .clk, .rstN, .start, .load(iterBus.load), .steps, .stepEn, .finish, .busy
  );

  divSqrtIter u_divSqrtIter (
    .clk, .rstN, .iterBus(iterBus), .stepEn, .q, .rem, .remNonZero
  );

  divSqrtPostproc u_divSqrtPostproc (
    .clk, .rstN, .finish, .op(opLatched), .divByZero, .dividend,
    .q, .rem, .remNonZero, .done, .result, .sticky, .remainder
  );

endmodule

`default_nettype wire

// File: tb/divSqrtRefPkg.sv
`default_nettype none

package divSqrtRefPkg;

  //////////////////////////////////////////////////////////////////////
  // Operand helpers
  //////////////////////////////////////////////////////////////////////

  // Fraction width of the format
  function automatic int fracBits(input divSqrtOpPkg::fmtT fmt);
    return (fmt == divSqrtOpPkg::FMT_S) ? divSqrtCfgPkg::NF_S : divSqrtCfgPkg::NF_H;
  endfunction

  // Fraction bits of x with the hidden one in front
  function automatic longint unsigned significand(input divSqrtOpPkg::fmtT fmt,
                                                  input logic [31:0] x);
    longint unsigned one;
    one = 64'd1 << fracBits(fmt);
    return one | (longint'(x) & (one - 1));
  endfunction

  // Nf+3 result bits for FP, one bit per step
  // Integer divide needs one step per significant dividend bit, at least one
  function automatic int stepCount(input divSqrtOpPkg::opT op, input divSqrtOpPkg::fmtT fmt,
                                   input logic [31:0] a);
    int n;
    if (op != divSqrtOpPkg::OP_IDIV) begin
      n = fracBits(fmt) + 3;
    end else begin
      n = 1;
      while ((a >> n) != 0)
        n++;
    end
    return n;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Expected results
  //////////////////////////////////////////////////////////////////////

  // Quotient of mA*2^(steps-1) by mB
  function automatic longint unsigned divQuotient(input divSqrtOpPkg::fmtT fmt,
                                                  input logic [31:0] a, input logic [31:0] b);
    return (significand(fmt, a) << (fracBits(fmt) + 2)) / significand(fmt, b);
  endfunction

  function automatic bit divInexact(input divSqrtOpPkg::fmtT fmt,
                                    input logic [31:0] a, input logic [31:0] b);
    return ((significand(fmt, a) << (fracBits(fmt) + 2)) % significand(fmt, b)) != 0;
  endfunction

  // Radicand mA*2^(Nf+4)
  function automatic longint unsigned radicand(input divSqrtOpPkg::fmtT fmt,
                                               input logic [31:0] a);
    return significand(fmt, a) << (fracBits(fmt) + 4);
  endfunction

  // Largest r with r*r not above the radicand, by bisection
  function automatic longint unsigned sqrtRoot(input divSqrtOpPkg::fmtT fmt,
                                               input logic [31:0] a);
    longint unsigned lo;
    longint unsigned hi;
    longint unsigned mid;
    longint unsigned rad;
    rad = radicand(fmt, a);
    lo = 0;
    hi = 64'd1 << 27;
    while (lo < hi) begin
      mid = (lo + hi + 1) >> 1;
      if (mid * mid <= rad)
        lo = mid;
      else
        hi = mid - 1;
    end
    return lo;
  endfunction

  function automatic bit sqrtInexact(input divSqrtOpPkg::fmtT fmt, input logic [31:0] a);
    longint unsigned r;
    r = sqrtRoot(fmt, a);
    return (r * r) != radicand(fmt, a);
  endfunction

  // Divide by zero gives all ones and keeps the dividend
  function automatic logic [31:0] intQuotient(input logic [31:0] a, input logic [31:0] b);
    return (b == 0) ? 32'hffff_ffff : a / b;
  endfunction

  function automatic logic [31:0] intRemainder(input logic [31:0] a, input logic [31:0] b);
    return (b == 0) ? a : a % b;
  endfunction

endpackage

`default_nettype wire

// File: tb/divSqrtTb.sv
`default_nettype none

module divSqrtTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RAND_PER_KIND = 60;
  localparam int NUM_KINDS = 5;
  localparam int NUM_DIRECTED = 12;
  localparam int NUM_OPS = RAND_PER_KIND * NUM_KINDS + NUM_DIRECTED;
  // 34 cycles of 4 ns per operation, doubled
  localparam int WATCHDOG_NS = NUM_OPS * 34 * 4 * 2;

  logic              clk;
  logic              rstN;
  logic              start;
  divSqrtOpPkg::opT  op;
  divSqrtOpPkg::fmtT fmt;
  logic [31:0]       opA;
  logic [31:0]       opB;
  logic              busy;
  logic              done;
  logic [31:0]       result;
  logic              sticky;
  logic [31:0]       remainder;
  logic [31:0]       lfsrState;
  // Set with the first start pulse
  logic              started;

  divSqrtTop u_divSqrtTop (
    .clk, .rstN, .start, .op, .fmt, .opA, .opB,
    .busy, .done, .result, .sticky, .remainder
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////////////////////////

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else abortRun($sformatf("FAILED %s expected 0x%08h got 0x%08h", name, exp, act));
  endtask

  // Done is a one cycle pulse inside busy, never before a start
  doneInBusy: assert property (@(posedge clk) disable iff (!rstN) done |-> busy)
    else abortRun("done was high while busy was low");
  donePulse: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
    else abortRun("done stayed high for more than one cycle");
  noEarlyDone: assert property (@(posedge clk) disable iff (!rstN) !started |-> !done)
    else abortRun("done rose before the first start");

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  // Starts at posedge+1, ends at posedge+1 one cycle after done
  task automatic runOp(input divSqrtOpPkg::opT o, input divSqrtOpPkg::fmtT f,
                       input logic [31:0] a, input logic [31:0] b, input bit poke);
    int          steps;
    logic [31:0] expRes;
    logic        expSticky;
    logic [31:0] expRem;
    steps = divSqrtRefPkg::stepCount(o, f, a);
    if (o == divSqrtOpPkg::OP_FDIV) begin
      expRes    = 32'(divSqrtRefPkg::divQuotient(f, a, b));
      expSticky = divSqrtRefPkg::divInexact(f, a, b);
      expRem    = '0;
    end else if (o == divSqrtOpPkg::OP_FSQRT) begin
      expRes    = 32'(divSqrtRefPkg::sqrtRoot(f, a));
      expSticky = divSqrtRefPkg::sqrtInexact(f, a);
      expRem    = '0;
    end else begin
      expRes    = divSqrtRefPkg::intQuotient(a, b);
      expSticky = 1'b0;
      expRem    = divSqrtRefPkg::intRemainder(a, b);
    end
    op      = o;
    fmt     = f;
    opA     = a;
    opB     = b;
    start   = 1'b1;
    started = 1'b1;
    @(posedge clk);
    #1;
    // Operands were taken at the start edge
    opA = ~a;
    opB = ~b;
    for (int k = 1; k <= steps + 2; k++) begin
      // Start while busy must be ignored
      start = poke && (k == 2);
      @(posedge clk);
      #1;
      checkValue($sformatf("busy %0d cycles after start", k), 32'h1, {31'h0, busy});
      checkValue($sformatf("done %0d cycles after start", k), {31'h0, k == steps + 2},
                 {31'h0, done});
    end
    start = 1'b0;
    checkValue("result", expRes, result);
    checkValue("sticky", {31'h0, expSticky}, {31'h0, sticky});
    checkValue("remainder", expRem, remainder);
    @(posedge clk);
    #1;
    // Masked starts leave no run behind
    checkValue("busy after done", 32'h0, {31'h0, busy});
    checkValue("done after done", 32'h0, {31'h0, done});
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    rstN      = 1'b0;
    start     = 1'b0;
    op        = divSqrtOpPkg::OP_FDIV;
    fmt       = divSqrtOpPkg::FMT_H;
    opA       = '0;
    opB       = '0;
    started   = 1'b0;
    lfsrState = 32'hf8eb_7e38;
    repeat (5) @(posedge clk);
    #1;
    rstN = 1'b1;
    checkValue("busy after reset", 32'h0, {31'h0, busy});
    checkValue("done after reset", 32'h0, {31'h0, done});
    // Idle for a while, done must stay low
    repeat (4) @(posedge clk);
    #1;

    // Directed edge cases
    runOp(divSqrtOpPkg::OP_FDIV, divSqrtOpPkg::FMT_H, 32'h0, 32'h0, 1'b0);
    runOp(divSqrtOpPkg::OP_FDIV, divSqrtOpPkg::FMT_S, 32'h7f_ffff, 32'h0, 1'b1);
    runOp(divSqrtOpPkg::OP_FDIV, divSqrtOpPkg::FMT_S, 32'h0, 32'h7f_ffff, 1'b0);
    runOp(divSqrtOpPkg::OP_FSQRT, divSqrtOpPkg::FMT_H, 32'h0, 32'h0, 1'b0);
    runOp(divSqrtOpPkg::OP_FSQRT, divSqrtOpPkg::FMT_S, 32'h7f_ffff, 32'h0, 1'b1);
    runOp(divSqrtOpPkg::OP_IDIV, divSqrtOpPkg::FMT_H, 32'h0, 32'h7, 1'b0);
    runOp(divSqrtOpPkg::OP_IDIV, divSqrtOpPkg::FMT_H, 32'h1, 32'h1, 1'b0);
    runOp(divSqrtOpPkg::OP_IDIV, divSqrtOpPkg::FMT_H, 32'hffff_ffff, 32'h3, 1'b1);
    runOp(divSqrtOpPkg::OP_IDIV, divSqrtOpPkg::FMT_H, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
    runOp(divSqrtOpPkg::OP_IDIV, divSqrtOpPkg::FMT_H, 32'hffff_ffff, 32'h1, 1'b0);
    runOp(divSqrtOpPkg::OP_IDIV, divSqrtOpPkg::FMT_H, 32'h1234_5678, 32'h0, 1'b1);
    runOp(divSqrtOpPkg::OP_IDIV, divSqrtOpPkg::FMT_H, 32'h0, 32'h0, 1'b0);

    // Random operands, every fourth run also pokes start while busy
    for (int i = 0; i < RAND_PER_KIND; i++) begin
      a = takeBits(divSqrtCfgPkg::NF_H);
      b = takeBits(divSqrtCfgPkg::NF_H);
      runOp(divSqrtOpPkg::OP_FDIV, divSqrtOpPkg::FMT_H, a, b, (i % 4) == 0);
      a = takeBits(divSqrtCfgPkg::NF_S);
      b = takeBits(divSqrtCfgPkg::NF_S);
      runOp(divSqrtOpPkg::OP_FDIV, divSqrtOpPkg::FMT_S, a, b, (i % 4) == 1);
      a = takeBits(divSqrtCfgPkg::NF_H);
      runOp(divSqrtOpPkg::OP_FSQRT, divSqrtOpPkg::FMT_H, a, '0, (i % 4) == 2);
      a = takeBits(divSqrtCfgPkg::NF_S);
      runOp(divSqrtOpPkg::OP_FSQRT, divSqrtOpPkg::FMT_S, a, '0, (i % 4) == 3);
      // Random shifts spread the dividend length over all step counts
      a = takeBits(32);
      a = a >> takeBits(5);
      b = takeBits(32);
      b = b >> takeBits(5);
      runOp(divSqrtOpPkg::OP_IDIV, divSqrtOpPkg::FMT_H, a, b, (i % 4) == 0);
    end

    $display("SIMULATION PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    abortRun("The run timed out before all operations completed");
  end

endmodule

`default_nettype wire

// File: project.f
common/divSqrtCfgPkg.sv
common/divSqrtOpPkg.sv
common/divSqrtIterIf.sv
divsqrt/divSqrtCycles.sv
divsqrt/divSqrtPreproc.sv
divsqrt/divSqrtIter.sv
divsqrt/divSqrtCtrl.sv
divsqrt/divSqrtPostproc.sv
hw/divSqrtTop.sv
tb/divSqrtRefPkg.sv
tb/divSqrtTb.sv
